/* switch_pkg.sv */
// Learning switch shared definitions
// Widths, stream types, register map and table sizes

package switch_pkg;

    localparam int NUM_PORTS   = 4;
    localparam int DATA_W      = 64;
    localparam int MAC_W       = 48;
    localparam int TABLE_DEPTH = 8;
    localparam int FIFO_DEPTH  = 32;

    // Index widths derived from the sizes above
    localparam int PORT_W      = $clog2(NUM_PORTS);
    localparam int TABLE_IDX_W = $clog2(TABLE_DEPTH);
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [MAC_W-1:0]     mac_t;
    typedef logic [PORT_W-1:0]    port_idx_t;
    typedef logic [NUM_PORTS-1:0] port_map_t;
    typedef logic [1:0]           reg_addr_t;
    typedef logic [31:0]          reg_data_t;

    // Register map
    localparam reg_addr_t REG_CTRL    = 2'd0;  // bit 0 learn enable, bit 1 flush
    localparam reg_addr_t REG_HITS    = 2'd1;
    localparam reg_addr_t REG_MISSES  = 2'd2;
    localparam reg_addr_t REG_LEARNED = 2'd3;

    // Header position inside the packet
    typedef enum logic [1:0] {
        HDR_DST,
        HDR_SRC,
        PAYLOAD
    } lookup_state_t;

endpackage

/* pkt_stream_if.sv */
// Packet stream bundle
// Valid/ready word stream with last marker and port sideband

interface pkt_stream_if;
    import switch_pkg::*;

    data_t     data;
    logic      valid;
    logic      last;
    logic      ready;
    port_idx_t src_port;  // Input port the packet came from
    port_map_t dst_map;   // One bit per output port

    modport src (output data, valid, last, src_port, dst_map, input ready);

    modport dst (input data, valid, last, src_port, dst_map, output ready);

endinterface

/* input_arbiter.sv */
// Input arbiter
// Round-robin merge of the input ports, one whole packet per grant

module input_arbiter (
    input  logic                                clk,
    input  logic                                reset,
    input  switch_pkg::data_t                   in_data [switch_pkg::NUM_PORTS],
    input  logic [switch_pkg::NUM_PORTS-1:0]    in_valid,
    input  logic [switch_pkg::NUM_PORTS-1:0]    in_last,
    output logic [switch_pkg::NUM_PORTS-1:0]    in_ready,
    pkt_stream_if.src                           out
);
    import switch_pkg::*;

    port_idx_t last_grant;  // Also the current grant while busy
    logic      busy;        // Packet in progress
    port_idx_t pick;
    logic      found;
    port_idx_t grant;
    logic      active;

    // Search starts one past the last granted input
    always_comb begin
        port_idx_t cand;
        pick  = last_grant;
        found = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = last_grant + port_idx_t'(i);
            if (!found && in_valid[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    assign grant  = busy ? last_grant : pick;
    assign active = busy || found;

    assign out.valid    = active && in_valid[grant];
    assign out.data     = in_data[grant];
    assign out.last     = in_last[grant];
    assign out.src_port = grant;
    assign out.dst_map  = '0;  // Filled in by the lookup stage

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_ready[i] = active && (grant == port_idx_t'(i)) && out.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            last_grant <= port_idx_t'(NUM_PORTS - 1);  // Input 0 goes first
        end else if (out.valid && out.ready) begin
            busy       <= !out.last;
            last_grant <= grant;
        end
    end

endmodule

/* mac_learning_table.sv */
// MAC learning table
// Small fully associative MAC to port map with learn, update and flush

module mac_learning_table (
    input  logic                  clk,
    input  logic                  reset,
    input  switch_pkg::mac_t      lookup_mac,
    output logic                  lookup_hit,
    output switch_pkg::port_idx_t lookup_port,
    input  logic                  learn_en_pulse,
    input  switch_pkg::mac_t      learn_mac,
    input  switch_pkg::port_idx_t learn_port,
    input  logic                  flush,
    output logic                  learned_pulse
);
    import switch_pkg::*;

    logic [TABLE_DEPTH-1:0] entry_valid;
    mac_t                   entry_mac  [TABLE_DEPTH];
    port_idx_t              entry_port [TABLE_DEPTH];

    logic                   match_found;
    logic [TABLE_IDX_W-1:0] match_idx;
    logic                   free_found;
    logic [TABLE_IDX_W-1:0] free_idx;
    logic [TABLE_IDX_W-1:0] repl_ptr;  // Victim when the table is full
    logic [TABLE_IDX_W-1:0] wr_idx;

    // Parallel compare for the lookup side
    always_comb begin
        lookup_hit  = 1'b0;
        lookup_port = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (entry_valid[i] && entry_mac[i] == lookup_mac) begin
                lookup_hit  = 1'b1;
                lookup_port = entry_port[i];
            end
        end
    end

    // Existing entry and first free slot for the learn side
    always_comb begin
        match_found = 1'b0;
        match_idx   = '0;
        free_found  = 1'b0;
        free_idx    = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && entry_mac[i] == learn_mac) begin
                match_found = 1'b1;
                match_idx   = TABLE_IDX_W'(i);
            end
            if (!entry_valid[i]) begin
                free_found = 1'b1;
                free_idx   = TABLE_IDX_W'(i);
            end
        end
    end

    assign wr_idx        = match_found ? match_idx : (free_found ? free_idx : repl_ptr);
    assign learned_pulse = learn_en_pulse && !flush && !match_found;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            entry_valid <= '0;
            if (reset) repl_ptr <= '0;
        end else if (learn_en_pulse) begin
            entry_valid[wr_idx] <= 1'b1;
            if (!match_found && !free_found) repl_ptr <= repl_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (learn_en_pulse) begin
            entry_mac[wr_idx]  <= learn_mac;  // Same MAC again on an update
            entry_port[wr_idx] <= learn_port;
        end
    end

endmodule

/* output_port_lookup.sv */
// Output port lookup
// Parses the MAC header, picks the destination bitmap and drives learning
// One output register between the arbiter stream and the queues

module output_port_lookup (
    input  logic      clk,
    input  logic      reset,
    pkt_stream_if.dst in,
    pkt_stream_if.src out,
    input  logic      learn_enable,
    input  logic      flush_in,
    output logic      hit_pulse,
    output logic      miss_pulse,
    output logic      learned_pulse
);
    import switch_pkg::*;

    lookup_state_t state;

    mac_t      lookup_mac;
    logic      lookup_hit;
    port_idx_t lookup_port;
    logic      learn_en_pulse;

    logic      accept;
    logic      is_bcast;
    port_map_t src_bit;
    port_map_t new_map;

    logic      out_valid_q;
    data_t     data_q;
    logic      last_q;
    port_idx_t src_q;
    port_map_t map_q;

    mac_learning_table i_mac_learning_table (
        .clk            (clk),
        .reset          (reset),
        .lookup_mac     (lookup_mac),
        .lookup_hit     (lookup_hit),
        .lookup_port    (lookup_port),
        .learn_en_pulse (learn_en_pulse),
        .learn_mac      (mac_t'(in.data[MAC_W-1:0])),
        .learn_port     (in.src_port),
        .flush          (flush_in),
        .learned_pulse  (learned_pulse)
    );

    // Register empty or draining this cycle
    assign in.ready = !out_valid_q || out.ready;
    assign accept   = in.valid && in.ready;

    assign lookup_mac = in.data[MAC_W-1:0];
    assign is_bcast   = &lookup_mac;
    assign src_bit    = port_map_t'(1) << in.src_port;

    always_comb begin
        if (lookup_hit && !is_bcast) begin
            new_map = (port_map_t'(1) << lookup_port) & ~src_bit;  // Empty on same port
        end else begin
            new_map = ~src_bit;  // Flood
        end
    end

    assign hit_pulse      = accept && state == HDR_DST && lookup_hit && !is_bcast;
    assign miss_pulse     = accept && state == HDR_DST && (!lookup_hit || is_bcast);
    assign learn_en_pulse = accept && state == HDR_SRC && learn_enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= HDR_DST;
            out_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                out_valid_q <= 1'b1;
                if (in.last) state <= HDR_DST;
                else if (state == HDR_DST) state <= HDR_SRC;
                else state <= PAYLOAD;
            end else if (out.ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in.data;
            last_q <= in.last;
            src_q  <= in.src_port;
            if (state == HDR_DST) map_q <= new_map;  // Held for the rest of the packet
        end
    end

    assign out.valid    = out_valid_q;
    assign out.data     = data_q;
    assign out.last     = last_q;
    assign out.src_port = src_q;
    assign out.dst_map  = map_q;

endmodule

/* switch_regs.sv */
// Switch registers
// Learning control plus hit, miss and learned counters on a simple reg port

module switch_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reg_wr,
    input  logic                  reg_rd,
    input  switch_pkg::reg_addr_t reg_addr,
    input  switch_pkg::reg_data_t reg_wdata,
    output switch_pkg::reg_data_t reg_rdata,
    output logic                  reg_rvalid,
    output logic                  learn_enable,
    output logic                  flush,
    input  logic                  hit_pulse,
    input  logic                  miss_pulse,
    input  logic                  learned_pulse
);
    import switch_pkg::*;

    reg_data_t hits;
    reg_data_t misses;
    reg_data_t learned;

    // Saturating count, cleared by a write to its address
    function automatic reg_data_t count_next(reg_data_t cnt, logic inc, logic clr);
        if (clr) return '0;
        if (inc && cnt != '1) return cnt + 1'b1;
        return cnt;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            learn_enable <= 1'b1;
            flush        <= 1'b0;
            hits         <= '0;
            misses       <= '0;
            learned      <= '0;
            reg_rvalid   <= 1'b0;
        end else begin
            if (reg_wr && reg_addr == REG_CTRL) learn_enable <= reg_wdata[0];
            flush      <= reg_wr && reg_addr == REG_CTRL && reg_wdata[1];  // One cycle
            hits       <= count_next(hits, hit_pulse, reg_wr && reg_addr == REG_HITS);
            misses     <= count_next(misses, miss_pulse, reg_wr && reg_addr == REG_MISSES);
            learned    <= count_next(learned, learned_pulse, reg_wr && reg_addr == REG_LEARNED);
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (reg_addr)
                REG_CTRL:   reg_rdata <= reg_data_t'(learn_enable);
                REG_HITS:   reg_rdata <= hits;
                REG_MISSES: reg_rdata <= misses;
                default:    reg_rdata <= learned;
            endcase
        end
    end

endmodule

/* output_queues.sv */
// Output queues
// One word FIFO per port, each packet copied to every port in its bitmap
// Input stalls until all target queues have room

module output_queues (
    input  logic                             clk,
    input  logic                             reset,
    pkt_stream_if.dst                        in,
    output switch_pkg::data_t                out_data [switch_pkg::NUM_PORTS],
    output logic [switch_pkg::NUM_PORTS-1:0] out_valid,
    output logic [switch_pkg::NUM_PORTS-1:0] out_last,
    input  logic [switch_pkg::NUM_PORTS-1:0] out_ready
);
    import switch_pkg::*;

    port_map_t full;
    port_map_t wr_en;
    logic      accept;

    // Empty map gives ready high, the word is then dropped
    assign in.ready = (in.dst_map & full) == '0;
    assign accept   = in.valid && in.ready;
    assign wr_en    = accept ? in.dst_map : '0;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_queue
        logic [DATA_W:0]     mem [FIFO_DEPTH];  // {last, data}
        logic [FIFO_PTR_W:0] wr_ptr;            // Extra bit tells full from empty
        logic [FIFO_PTR_W:0] rd_ptr;
        logic                empty;
        logic                rd_en;

        assign empty   = wr_ptr == rd_ptr;
        assign full[p] = (wr_ptr[FIFO_PTR_W] != rd_ptr[FIFO_PTR_W]) &&
                         (wr_ptr[FIFO_PTR_W-1:0] == rd_ptr[FIFO_PTR_W-1:0]);

        assign out_valid[p] = !empty;
        assign {out_last[p], out_data[p]} = mem[rd_ptr[FIFO_PTR_W-1:0]];
        assign rd_en = out_valid[p] && out_ready[p];

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (wr_en[p]) wr_ptr <= wr_ptr + 1'b1;
                if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (wr_en[p]) begin
                mem[wr_ptr[FIFO_PTR_W-1:0]] <= {in.last, in.data};
            end
        end
    end

endmodule

/* learning_switch_top.sv */
// Learning switch top level
// Arbiter, lookup with registers, and output queues on plain ports

module learning_switch_top (
    input  logic                             clk,
    input  logic                             reset,
    input  switch_pkg::data_t                in_data [switch_pkg::NUM_PORTS],
    input  logic [switch_pkg::NUM_PORTS-1:0] in_valid,
    input  logic [switch_pkg::NUM_PORTS-1:0] in_last,
    output logic [switch_pkg::NUM_PORTS-1:0] in_ready,
    output switch_pkg::data_t                out_data [switch_pkg::NUM_PORTS],
    output logic [switch_pkg::NUM_PORTS-1:0] out_valid,
    output logic [switch_pkg::NUM_PORTS-1:0] out_last,
    input  logic [switch_pkg::NUM_PORTS-1:0] out_ready,
    input  logic                             reg_wr,
    input  logic                             reg_rd,
    input  switch_pkg::reg_addr_t            reg_addr,
    input  switch_pkg::reg_data_t            reg_wdata,
    output switch_pkg::reg_data_t            reg_rdata,
    output logic                             reg_rvalid
);

    logic learn_enable;
    logic flush;
    logic hit_pulse;
    logic miss_pulse;
    logic learned_pulse;

    pkt_stream_if arb_s ();
    pkt_stream_if opl_s ();

    input_arbiter i_input_arbiter (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_last  (in_last),
        .in_ready (in_ready),
        .out      (arb_s.src)
    );

    output_port_lookup i_output_port_lookup (
        .clk           (clk),
        .reset         (reset),
        .in            (arb_s.dst),
        .out           (opl_s.src),
        .learn_enable  (learn_enable),
        .flush_in      (flush),
        .hit_pulse     (hit_pulse),
        .miss_pulse    (miss_pulse),
        .learned_pulse (learned_pulse)
    );

    switch_regs i_switch_regs (
        .clk           (clk),
        .reset         (reset),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .reg_rvalid    (reg_rvalid),
        .learn_enable  (learn_enable),
        .flush         (flush),
        .hit_pulse     (hit_pulse),
        .miss_pulse    (miss_pulse),
        .learned_pulse (learned_pulse)
    );

    output_queues i_output_queues (
        .clk       (clk),
        .reset     (reset),
        .in        (opl_s.dst),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

/* learning_switch_assert.sv */
// Learning switch port assertions
// Output hold under back-pressure, quiet reset, register read timing, single grant

module learning_switch_assert (
    input logic                             clk,
    input logic                             reset,
    input logic [switch_pkg::NUM_PORTS-1:0] in_ready,
    input switch_pkg::data_t                out_data [switch_pkg::NUM_PORTS],
    input logic [switch_pkg::NUM_PORTS-1:0] out_valid,
    input logic [switch_pkg::NUM_PORTS-1:0] out_last,
    input logic [switch_pkg::NUM_PORTS-1:0] out_ready,
    input logic                             reg_rd,
    input logic                             reg_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;
    import switch_pkg::*;

    int fail_count = 0;  // Summed into the testbench error count

    // A stalled output word must not change
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        hold_when_stalled: assert property (
            @(posedge clk) disable iff (reset)
            out_valid[p] && !out_ready[p] |=> $stable(out_data[p]) && $stable(out_last[p])
        ) else begin
            $error("Output port %0d changed while out_ready was low", p);
            fail_count++;
        end
    end

    quiet_after_reset: assert property (
        @(posedge clk) $past(reset) |-> out_valid == '0 && in_ready == '0
    ) else begin
        $error("out_valid or in_ready high during or right after reset");
        fail_count++;
    end

    rvalid_after_rd: assert property (@(posedge clk) disable iff (reset) reg_rd |=> reg_rvalid)
    else begin
        $error("reg_rvalid missing one cycle after reg_rd");
        fail_count++;
    end

    no_stray_rvalid: assert property (@(posedge clk) disable iff (reset) !reg_rd |=> !reg_rvalid)
    else begin
        $error("reg_rvalid high without a read the cycle before");
        fail_count++;
    end

    single_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(in_ready))
    else begin
        $error("More than one in_ready high");
        fail_count++;
    end

endmodule

bind learning_switch_top learning_switch_assert i_learning_switch_assert (
    .clk        (clk),
    .reset      (reset),
    .in_ready   (in_ready),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_ready  (out_ready),
    .reg_rd     (reg_rd),
    .reg_rvalid (reg_rvalid)
);

/* tb_learning_switch.sv */
// Learning switch testbench
// Sends packets through the switch and checks every output word against a
// reference model of the learning table, plus the register counters

module tb_learning_switch;
    timeunit 1ns;
    timeprecision 1ps;
    import switch_pkg::*;

    localparam int   TIMEOUT = 5000;  // Cycles per wait
    localparam mac_t MAC_A = 48'h02_00_00_00_00_0a;
    localparam mac_t MAC_B = 48'h02_00_00_00_00_0b;
    localparam mac_t MAC_C = 48'h02_00_00_00_00_0c;
    localparam mac_t MAC_D = 48'h02_00_00_00_00_0d;
    localparam mac_t MAC_E = 48'h02_00_00_00_00_0e;
    localparam mac_t MAC_F = 48'h02_00_00_00_00_0f;
    localparam mac_t MAC_X = 48'h02_00_00_00_00_99;  // Never used as a source

    logic                 clk;
    logic                 reset;
    data_t                in_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_last;
    logic [NUM_PORTS-1:0] in_ready;
    data_t                out_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_last;
    logic [NUM_PORTS-1:0] out_ready;
    logic                 reg_wr;
    logic                 reg_rd;
    reg_addr_t            reg_addr;
    reg_data_t            reg_wdata;
    reg_data_t            reg_rdata;
    logic                 reg_rvalid;

    logic [DATA_W:0] exp_q [NUM_PORTS][$];  // {last, data} still due per port
    data_t           pkt [NUM_PORTS][$];    // Packet being sent per input
    port_idx_t       tbl [mac_t];           // Model learning table
    port_idx_t       last_grant;
    logic            learn_on;
    logic            rand_ready;
    int              exp_hits;
    int              exp_misses;
    int              exp_learned;
    int              errors;
    int              err_start;
    int              tests_run;
    int              tests_passed;

    learning_switch_top i_learning_switch_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int total_errors();
        return errors + i_learning_switch_top.i_learning_switch_assert.fail_count;
    endfunction

    task automatic check_value(string name, data_t got, data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_fail(string what);
        $display("Timeout at %0t waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    // Output monitors pop the expected words in order
    always @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!reset && out_valid[p] && out_ready[p]) begin
                if (exp_q[p].size() == 0) begin
                    $display("Unexpected word on output port %0d at %0t", p, $time);
                    errors++;
                end else begin
                    check_value($sformatf("out_data[%0d]", p), out_data[p], exp_q[p][0][DATA_W-1:0]);
                    check_value($sformatf("out_last[%0d]", p), out_last[p], exp_q[p][0][DATA_W]);
                    void'(exp_q[p].pop_front());
                end
            end
        end
    end

    always @(negedge clk) begin
        out_ready = rand_ready ? NUM_PORTS'($urandom) : '1;
    end

    task automatic build_pkt(int p, mac_t dst, mac_t src, int n_payload);
        pkt[p].delete();
        pkt[p].push_back({16'h0, dst});
        pkt[p].push_back({16'h0, src});
        repeat (n_payload) pkt[p].push_back({$urandom, $urandom});
    endtask

    // Reference forwarding decision and learning, in arbitration order
    task automatic model_pkt(int p);
        mac_t      dst;
        mac_t      src;
        port_map_t map;
        dst = pkt[p][0][MAC_W-1:0];
        src = pkt[p][1][MAC_W-1:0];
        if (tbl.exists(dst) && dst != '1) begin
            map = port_map_t'(1 << tbl[dst]) & ~port_map_t'(1 << p);
            exp_hits++;
        end else begin
            map = ~port_map_t'(1 << p);  // Flood, broadcast too
            exp_misses++;
        end
        if (learn_on) begin
            if (!tbl.exists(src)) exp_learned++;
            tbl[src] = port_idx_t'(p);
        end
        for (int q = 0; q < NUM_PORTS; q++) begin
            if (map[q]) begin
                for (int i = 0; i < pkt[p].size(); i++) begin
                    exp_q[q].push_back({i == pkt[p].size() - 1, pkt[p][i]});
                end
            end
        end
        last_grant = port_idx_t'(p);
    endtask

    task automatic drive_pkt(int p);
        int t;
        for (int i = 0; i < pkt[p].size(); i++) begin
            @(negedge clk);
            in_data[p]  = pkt[p][i];
            in_last[p]  = (i == pkt[p].size() - 1);
            in_valid[p] = 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
                if (t > TIMEOUT) timeout_fail($sformatf("in_ready on port %0d", p));
            end while (!in_ready[p]);
        end
        @(negedge clk);
        in_valid[p] = 1'b0;
        in_last[p]  = 1'b0;
    endtask

    task automatic reg_write(reg_addr_t addr, reg_data_t data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_check(reg_addr_t addr, reg_data_t exp);
        int t;
        @(negedge clk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) timeout_fail("reg_rvalid");
        end while (!reg_rvalid);
        check_value($sformatf("reg_rdata[addr %0d]", addr), reg_rdata, exp);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) timeout_fail("expected output words");
        end
        repeat (4) @(posedge clk);  // Stray copies would show up here
    endtask

    task automatic send(int p, mac_t dst, mac_t src, int n_payload);
        build_pkt(p, dst, src, n_payload);
        model_pkt(p);
        drive_pkt(p);
        wait_drain();
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (total_errors() == err_start) tests_passed++;
        $display("Test %0d %s: %s", tests_run, name, total_errors() == err_start ? "pass" : "FAIL");
        err_start = total_errors();
    endtask

    initial begin
        port_idx_t first;
        void'($urandom(32'h26c4));
        reset       = 1'b1;
        in_data     = '{default: '0};
        in_valid    = '0;
        in_last     = '0;
        out_ready   = '1;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        learn_on    = 1'b1;
        rand_ready  = 1'b0;
        last_grant  = port_idx_t'(NUM_PORTS - 1);
        exp_hits    = 0;
        exp_misses  = 0;
        exp_learned = 0;
        errors      = 0;
        err_start   = 0;
        tests_run   = 0;
        tests_passed = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        reg_check(REG_CTRL, 32'd1);
        reg_check(REG_HITS, 32'd0);
        reg_check(REG_MISSES, 32'd0);
        reg_check(REG_LEARNED, 32'd0);
        end_test("reset state");

        send(0, MAC_X, MAC_A, 3);  // A learned on port 0
        reg_check(REG_MISSES, exp_misses);
        reg_check(REG_LEARNED, exp_learned);
        end_test("flooding");

        send(2, MAC_A, MAC_B, 4);
        reg_check(REG_HITS, exp_hits);
        send(0, MAC_A, MAC_C, 2);  // Destination behind its own port
        end_test("unicast and same-port drop");

        reg_write(REG_CTRL, 32'd0);
        learn_on = 1'b0;
        send(1, MAC_B, MAC_D, 2);
        reg_write(REG_CTRL, 32'd1);
        learn_on = 1'b1;
        send(3, MAC_D, MAC_E, 2);  // D never learned
        reg_write(REG_CTRL, 32'd3);
        tbl.delete();
        send(3, MAC_A, MAC_F, 2);
        reg_check(REG_LEARNED, exp_learned);
        end_test("learning control");

        // All four inputs at once, each destination learned by an earlier one
        rand_ready = 1'b1;
        build_pkt(0, MAC_F, MAC_B, $urandom_range(6, 1));
        build_pkt(1, MAC_B, MAC_C, $urandom_range(6, 1));
        build_pkt(2, '1, MAC_D, $urandom_range(6, 1));
        build_pkt(3, MAC_C, MAC_E, $urandom_range(6, 1));
        first = last_grant + 1'b1;
        for (int k = 0; k < NUM_PORTS; k++) model_pkt(int'(port_idx_t'(first + k)));
        fork
            drive_pkt(0);
            drive_pkt(1);
            drive_pkt(2);
            drive_pkt(3);
        join
        wait_drain();
        rand_ready = 1'b0;
        reg_check(REG_HITS, exp_hits);
        reg_check(REG_MISSES, exp_misses);
        end_test("contention");

        $display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, total_errors());
        if (total_errors() == 0 && tests_passed == tests_run) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
switch_pkg.sv
pkt_stream_if.sv
input_arbiter.sv
mac_learning_table.sv
output_port_lookup.sv
switch_regs.sv
output_queues.sv
learning_switch_top.sv
learning_switch_assert.sv
tb_learning_switch.sv
